//--- hdl/mem_agg_consts.svh
/* Sizes for the wide memory built from narrow slices. MEM_N_SLICES must be at least 2;
   slice i reads with a latency of MEM_BASE_LAT + i cycles */
`ifndef MEM_AGG_CONSTS_SVH
`define MEM_AGG_CONSTS_SVH

// Number of narrow slices behind the wide port
`define MEM_N_SLICES    4

`define MEM_SLICE_DW    16  // Bits per slice
`define MEM_AW          8   // 256 words

// Read latency of slice 0
`define MEM_BASE_LAT    2

// Entries per alignment FIFO, also the limit on reads in flight
`define MEM_ALIGN_DEPTH 8

`endif

//--- hdl/mem_pkg.sv
/* Address and data types shared by the slices and the aggregate.
   The wide word holds slice 0 in its least significant bits */
`include "mem_agg_consts.svh"

package mem_pkg;

    // Word address, same for every slice
    typedef logic [`MEM_AW-1:0] addr_t;

    // One slice's part of the wide word
    typedef logic [`MEM_SLICE_DW-1:0] slice_data_t;

    // All slices merged
    typedef logic [`MEM_N_SLICES*`MEM_SLICE_DW-1:0] wide_data_t;

endpackage : mem_pkg

//--- hdl/agg_pkg.sv
/* Status types of the read aggregate, sized for MEM_N_SLICES slices */
`include "mem_agg_consts.svh"

package agg_pkg;

    // One flag per slice FIFO, sticky until reset
    typedef struct packed {
        logic [`MEM_N_SLICES-1:0] oflow;
        logic [`MEM_N_SLICES-1:0] uflow;
    } align_err_t;

    // Must reach MEM_ALIGN_DEPTH itself
    typedef logic [$clog2(`MEM_ALIGN_DEPTH+1)-1:0] inflight_t;

endpackage : agg_pkg

//--- hdl/mem_rd_intf.sv
/* Narrow read port of one slice. A read is taken when req and rdy are high;
   ack is a single-cycle strobe with data and cannot be held off */
`timescale 1ns/100ps

interface mem_rd_intf
    import mem_pkg::*;
();

    logic        req;
    addr_t       addr;
    logic        rdy;
    logic        ack;
    slice_data_t data;

    // Aggregate side
    modport controller (
        output req,
        output addr,
        input  rdy,
        input  ack,
        input  data
    );

    // Slice side
    modport peripheral (
        input  req,
        input  addr,
        output rdy,
        output ack,
        output data
    );

endinterface : mem_rd_intf

//--- hdl/align_fifo.sv
/* Show-ahead FIFO, rd_data is valid whenever rd_vld is high.
   Writes when full and reads when empty are dropped and flagged for one cycle */
`timescale 1ns/100ps
`include "mem_agg_consts.svh"

module align_fifo
    import mem_pkg::*;
#(
    parameter int DEPTH = `MEM_ALIGN_DEPTH
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wr,
    input  slice_data_t wr_data,
    input  logic        rd,
    output logic        rd_vld,
    output slice_data_t rd_data,
    output logic        oflow,
    output logic        uflow
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    slice_data_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic empty;
    logic do_wr;
    logic do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign rd_vld  = !empty;
    assign rd_data = mem[rd_ptr];  // Head entry

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            oflow  <= 1'b0;
            uflow  <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
            oflow <= wr && full;
            uflow <= rd && empty;
        end
    end

endmodule : align_fifo

//--- hdl/mem_slice.sv
/* One narrow slice with a fixed read latency of LATENCY cycles (at least 1).
   A write in the same cycle wins, rdy is low then */
`timescale 1ns/100ps
`include "mem_agg_consts.svh"

module mem_slice
    import mem_pkg::*;
#(
    parameter int LATENCY = `MEM_BASE_LAT
) (
    input  logic        clk,
    input  logic        arst_n,
    mem_rd_intf.peripheral rd,
    input  logic        wr,
    input  addr_t       wr_addr,
    input  slice_data_t wr_data
);

    slice_data_t ram [2**`MEM_AW];

    logic [LATENCY-1:0] vld_pipe;
    slice_data_t        data_pipe [LATENCY];
    logic               accept;

    assign rd.rdy = !wr;
    assign accept = rd.req && rd.rdy;

    always_ff @(posedge clk) begin
        if (wr) ram[wr_addr] <= wr_data;
    end

    // Read data moves along with its valid bit
    always_ff @(posedge clk) begin
        data_pipe[0] <= ram[rd.addr];
        for (int k = 1; k < LATENCY; k++) begin
            data_pipe[k] <= data_pipe[k-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= accept;
            for (int k = 1; k < LATENCY; k++) begin
                vld_pipe[k] <= vld_pipe[k-1];
            end
        end
    end

    assign rd.ack  = vld_pipe[LATENCY-1];
    assign rd.data = data_pipe[LATENCY-1];

endmodule : mem_slice

//--- hdl/mem_rd_aggregate.sv
/* Splits one wide read into N narrow reads and realigns the answers.
   N must equal MEM_N_SLICES (2 or more); err flags stay set until reset */
`timescale 1ns/100ps
`include "mem_agg_consts.svh"

module mem_rd_aggregate
    import mem_pkg::*;
    import agg_pkg::*;
#(
    parameter int N = `MEM_N_SLICES,
    parameter int ALIGNMENT_DEPTH = `MEM_ALIGN_DEPTH
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req,
    input  addr_t      addr,
    output logic       rdy,
    output logic       ack,
    output wide_data_t data,
    output align_err_t err,
    mem_rd_intf.controller to_slice [N]
);

    logic [N-1:0]              rdy_vec;
    logic [N-1:0]              vld_vec;
    logic [N-1:0]              oflow_vec;
    logic [N-1:0]              uflow_vec;
    slice_data_t [N-1:0]       head;
    inflight_t                 inflight;
    logic                      accept;

    for (genvar i = 0; i < N; i++) begin : g__slice
        assign to_slice[i].req  = accept;  // Slices only see reads taken here
        assign to_slice[i].addr = addr;
        assign rdy_vec[i]       = to_slice[i].rdy;

        // Hold early answers until the slowest slice catches up
        align_fifo #(
            .DEPTH   ( ALIGNMENT_DEPTH )
        ) i_align_fifo (
            .clk     ( clk ),
            .arst_n  ( arst_n ),
            .wr      ( to_slice[i].ack ),
            .wr_data ( to_slice[i].data ),
            .rd      ( ack ),
            .rd_vld  ( vld_vec[i] ),
            .rd_data ( head[i] ),
            .oflow   ( oflow_vec[i] ),
            .uflow   ( uflow_vec[i] )
        );
    end : g__slice

    assign rdy    = (&rdy_vec) && (inflight < inflight_t'(ALIGNMENT_DEPTH));
    assign accept = req && rdy;
    assign ack    = &vld_vec;
    assign data   = head;  // Slice 0 lands in the low bits

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight <= '0;
        end else if (accept && !ack) begin
            inflight <= inflight + 1'b1;
        end else if (ack && !accept) begin
            inflight <= inflight - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err <= '0;
        end else begin
            err.oflow <= err.oflow | oflow_vec;
            err.uflow <= err.uflow | uflow_vec;
        end
    end

endmodule : mem_rd_aggregate

//--- hdl/wide_mem_top.sv
/* Wide memory of MEM_N_SLICES slices. rd_ack comes MEM_BASE_LAT + MEM_N_SLICES
   cycles after an accepted read; requests while rd_rdy is low are dropped */
`timescale 1ns/100ps
`include "mem_agg_consts.svh"

module wide_mem_top
    import mem_pkg::*;
    import agg_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rd_req,
    input  addr_t      rd_addr,
    output logic       rd_rdy,
    output logic       rd_ack,
    output wide_data_t rd_data,
    input  logic       wr,
    input  addr_t      wr_addr,
    input  wide_data_t wr_data,
    output align_err_t err
);

    mem_rd_intf slice_if [`MEM_N_SLICES] ();

    mem_rd_aggregate #(
        .N               ( `MEM_N_SLICES ),
        .ALIGNMENT_DEPTH ( `MEM_ALIGN_DEPTH )
    ) i_mem_rd_aggregate (
        .clk      ( clk ),
        .arst_n   ( arst_n ),
        .req      ( rd_req ),
        .addr     ( rd_addr ),
        .rdy      ( rd_rdy ),
        .ack      ( rd_ack ),
        .data     ( rd_data ),
        .err      ( err ),
        .to_slice ( slice_if )
    );

    for (genvar i = 0; i < `MEM_N_SLICES; i++) begin : g__slice
        mem_slice #(
            .LATENCY ( `MEM_BASE_LAT + i )  // Each slice one cycle slower
        ) i_mem_slice (
            .clk     ( clk ),
            .arst_n  ( arst_n ),
            .rd      ( slice_if[i] ),
            .wr      ( wr ),
            .wr_addr ( wr_addr ),
            .wr_data ( wr_data[i*`MEM_SLICE_DW +: `MEM_SLICE_DW] )
        );
    end : g__slice

endmodule : wide_mem_top

//--- verif/wide_mem_checker.sv
/* Protocol checks on wide_mem_top. Failures are counted in fails;
   the outstanding count is rebuilt here from rd_req, rd_rdy and rd_ack */
`timescale 1ns/100ps
`include "mem_agg_consts.svh"

module wide_mem_checker
    import agg_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       rd_req,
    input logic       rd_rdy,
    input logic       rd_ack,
    input logic       wr,
    input align_err_t err
);

    localparam int LAT = `MEM_BASE_LAT + `MEM_N_SLICES;
    localparam int OW  = $clog2(`MEM_ALIGN_DEPTH + 1) + 1;  // Spare bit shows overrun

    int unsigned   fails = 0;
    logic [OW-1:0] outstanding;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + OW'(rd_req && rd_rdy) - OW'(rd_ack);
        end
    end

    a_lat: assert property (@(posedge clk) disable iff (!arst_n)
        rd_req && rd_rdy |-> ##LAT rd_ack)
        else begin fails++; $error("rd_ack missing %0d cycles after accept", LAT); end

    a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
        rd_ack |-> $past(rd_req && rd_rdy, LAT))
        else begin fails++; $error("rd_ack without a matching accept"); end

    a_wr_blocks: assert property (@(posedge clk) disable iff (!arst_n) wr |-> !rd_rdy)
        else begin fails++; $error("rd_rdy high during a write"); end

    a_full_blocks: assert property (@(posedge clk) disable iff (!arst_n)
        outstanding == OW'(`MEM_ALIGN_DEPTH) |-> !rd_rdy)
        else begin fails++; $error("rd_rdy high with alignment FIFOs full"); end

    a_depth: assert property (@(posedge clk) disable iff (!arst_n)
        outstanding <= OW'(`MEM_ALIGN_DEPTH))
        else begin fails++; $error("Outstanding reads exceed FIFO depth"); end

    a_no_err: assert property (@(posedge clk) disable iff (!arst_n) err == '0)
        else begin fails++; $error("Alignment error flag set"); end

endmodule : wide_mem_checker

bind wide_mem_top wide_mem_checker wide_mem_checker_i (.*);

//--- verif/wide_mem_tb.sv
/* Testbench for wide_mem_top. Fill pattern assumes 8-bit addresses and 16-bit slices;
   outputs are sampled on the falling edge */
`timescale 1ns/100ps
`include "mem_agg_consts.svh"

module wide_mem_tb
    import mem_pkg::*;
    import agg_pkg::*;
();

    localparam int N_FILL   = 2**`MEM_AW;
    localparam int N_RAND   = 64;
    localparam int N_BURST  = 64;
    localparam int N_MIXED  = 128;
    localparam int TIMEOUT  = (N_FILL + N_RAND + N_FILL + N_BURST + N_MIXED) * 8 + 200;

    logic       clk, arst_n, rd_req, rd_rdy, rd_ack, wr;
    addr_t      rd_addr, wr_addr;
    wide_data_t rd_data, wr_data;
    align_err_t err;

    wide_data_t  ref_mem [2**`MEM_AW];  // Mirror of every write
    wide_data_t  exp_q [$];             // Expected data, oldest read first
    logic [31:0] rng = 32'd61;
    int errors = 0, tests = 0, cycles = 0, n_acc = 0, n_checked = 0;

    wide_mem_top wide_mem_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Each slice part differs and depends on the full address
    function automatic wide_data_t fill_word(addr_t a);
        wide_data_t w;
        for (int i = 0; i < `MEM_N_SLICES; i++) begin
            w[i*`MEM_SLICE_DW +: `MEM_SLICE_DW] = slice_data_t'({a ^ addr_t'(i * 60), a});
        end
        return w;
    endfunction

    function automatic int total_errors();
        return errors + wide_mem_top_i.wide_mem_checker_i.fails;
    endfunction

    task automatic expect_equal(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests++;
        $display("test %-10s %s", name, (total_errors() == err_before) ? "ok" : "FAILED");
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic single_read(addr_t a);
        int start;
        start = n_acc;
        @(posedge clk);
        rd_req  <= 1'b1;
        rd_addr <= a;
        do @(posedge clk); while (n_acc == start);
        rd_req <= 1'b0;
        drain();
    endtask

    // Inputs seen here are the ones the DUT takes on the next rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (rd_ack) begin
                assert (exp_q.size() > 0) else begin
                    $display("rd_ack arrived with no read outstanding");
                    errors++;
                end
                if (exp_q.size() > 0) expect_equal("rd_data", rd_data, exp_q.pop_front());
                n_checked++;
            end
            if (wr) ref_mem[wr_addr] = wr_data;
            if (rd_req && rd_rdy) begin
                exp_q.push_back(ref_mem[rd_addr]);
                n_acc++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d reads unanswered", cycles, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int         e;
        logic [31:0] r;
        arst_n = 1'b0;
        rd_req = 1'b0;
        rd_addr = '0;
        wr = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        e = total_errors();
        repeat (3) begin
            @(negedge clk);
            expect_equal("rd_rdy", rd_rdy, 1);
            expect_equal("rd_ack", rd_ack, 0);
            expect_equal("err", err, 0);
        end
        end_test("reset", e);

        e = total_errors();
        for (int a = 0; a < N_FILL; a++) begin
            @(posedge clk);
            wr      <= 1'b1;
            wr_addr <= addr_t'(a);
            wr_data <= fill_word(addr_t'(a));
        end
        repeat (N_RAND) begin
            @(posedge clk);
            wr_addr <= addr_t'(next_rand());
            wr_data <= {next_rand(), next_rand()};
        end
        @(posedge clk);
        wr <= 1'b0;
        end_test("write", e);

        e = total_errors();
        for (int a = 0; a < N_FILL; a++) single_read(addr_t'(a));
        end_test("read_back", e);

        e = total_errors();
        repeat (N_BURST) begin
            @(posedge clk);
            rd_req  <= 1'b1;  // Held high, a new address every cycle
            rd_addr <= addr_t'(next_rand());
        end
        @(posedge clk);
        rd_req <= 1'b0;
        drain();
        end_test("burst", e);

        e = total_errors();
        repeat (N_MIXED) begin
            r = next_rand();
            @(posedge clk);
            wr      <= r[0] & r[1];
            wr_addr <= r[15:8];
            wr_data <= {next_rand(), next_rand()};
            rd_req  <= r[2];
            rd_addr <= r[23:16];
        end
        @(posedge clk);
        wr     <= 1'b0;
        rd_req <= 1'b0;
        drain();
        end_test("mixed", e);

        $display("%0d tests, %0d reads checked, %0d errors", tests, n_checked, total_errors());
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : wide_mem_tb

//--- compile.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/agg_pkg.sv
hdl/mem_rd_intf.sv
hdl/align_fifo.sv
hdl/mem_slice.sv
hdl/mem_rd_aggregate.sv
hdl/wide_mem_top.sv
verif/wide_mem_checker.sv
verif/wide_mem_tb.sv

//--- Bender.yml
package:
  name: wide_mem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_pkg.sv
      - hdl/agg_pkg.sv
      - hdl/mem_rd_intf.sv
      - hdl/align_fifo.sv
      - hdl/mem_slice.sv
      - hdl/mem_rd_aggregate.sv
      - hdl/wide_mem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/wide_mem_checker.sv
      - verif/wide_mem_tb.sv
